// File: build.f
+incdir+testbench
logic/corePkg.sv
logic/hostPort.sv
logic/instrBuffer.sv
logic/decodeStage.sv
logic/regFile.sv
logic/executeStage.sv
logic/resultStage.sv
logic/miniCore.sv
testbench/tbMiniCore.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tbMiniCore
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Simulation completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Pass message not found in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: testbench/refModel.svh
`ifndef REF_MODEL_SVH
`define REF_MODEL_SVH

// Register file model kept inside the testbench module
logic [31:0] modelRegs [32];
logic [15:0] modelImmHigh;
logic        modelPrefixed;

function automatic void modelReset();
  modelRegs = '{default: 32'd0};
  modelImmHigh = 16'd0;
  modelPrefixed = 1'b0;
endfunction

// Applies one accepted instruction word in program order
function automatic void modelApply(input logic [31:0] instr);
  logic [5:0] opc;
  logic [4:0] rd;
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] imm;
  logic [31:0] r;
  logic write;
  opc = instr[31:26];
  rd = instr[25:21];
  a = modelRegs[instr[20:16]];
  b = modelRegs[instr[15:11]];
  // Prefixed immediates take the high half from the last IMM
  imm = modelPrefixed ? {modelImmHigh, instr[15:0]} : {{16{instr[15]}}, instr[15:0]};
  write = 1'b1;
  case (opc)
    6'o00: r = a + b;
    6'o01: r = b - a;
    6'o10: r = a + imm;
    6'o11: r = imm - a;
    6'o40: r = a | b;
    6'o41: r = a & b;
    6'o42: r = a ^ b;
    6'o50: r = a | imm;
    6'o51: r = a & imm;
    6'o52: r = a ^ imm;
    default: begin
      r = 32'd0;
      write = 1'b0;
    end
  endcase
  if (opc == 6'o54) begin
    modelImmHigh = instr[15:0];
  end
  if (write && rd != 5'd0) begin
    modelRegs[rd] = r;
  end
  modelPrefixed = (opc == 6'o54);
endfunction

// One counted pulse means one counter increment
function automatic void modelInterrupt();
  modelRegs[INT_REG] = modelRegs[INT_REG] + 32'd1;
endfunction

`endif

// File: testbench/tbMiniCore.sv
`timescale 1ns/1ns

module tbMiniCore;
  import corePkg::*;

  localparam int INT_REG = 14;
  localparam int NUM_RANDOM = 200;
  localparam int NUM_IMM_ROUNDS = 40;
  localparam int NUM_INT_OPS = 150;
  localparam int NUM_QUIET_OPS = 20;
  localparam int NUM_UNKNOWN = 20;
  localparam int NUM_REG_SWEEPS = 6;
  localparam int NUM_ACCESSES = 40 + NUM_RANDOM + 3 * NUM_IMM_ROUNDS + 2 * NUM_INT_OPS +
                                NUM_QUIET_OPS + NUM_UNKNOWN + 32 * NUM_REG_SWEEPS;
  // Worst case about 8 cycles per access plus drain waits and reset
  localparam int TIMEOUT_CYCLES = NUM_ACCESSES * 8 + 500;

  logic gclk;
  logic grst;
  apbReq_t apbReq;
  apbRsp_t apbRsp;
  logic intReq;

  logic [31:0] rngState = 32'd75564;
  logic pulseOn = 1'b0;
  logic intEnableModel = 1'b0;
  int pulseCount = 0;
  int cycleCount = 0;
  int checks = 0;
  int errors = 0;
  // Sixteen entries so a 4-bit random index covers the table
  logic [5:0] aluOps [16] = '{6'o00, 6'o01, 6'o40, 6'o41, 6'o42, 6'o10, 6'o11, 6'o50,
                              6'o51, 6'o52, 6'o00, 6'o01, 6'o40, 6'o41, 6'o42, 6'o10};
  logic [11:0] badAddrs [8] = '{12'h008, 12'h07C, 12'h100, 12'h800,
                                12'hFFC, 12'h082, 12'h003, 12'h0FE};

  `include "refModel.svh"

  miniCore #(.intCountReg(INT_REG)) dut (.gclk, .grst, .apbReq, .apbRsp, .intReq);

  initial begin
    gclk = 1'b0;
    forever #4 gclk = ~gclk;
  end

  always @(posedge gclk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= TIMEOUT_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Simulation failed");
      $finish;
    end
  end

  function automatic logic [31:0] nextRand();
    rngState = rngState ^ (rngState << 13);
    rngState = rngState ^ (rngState >> 17);
    rngState = rngState ^ (rngState << 5);
    return rngState;
  endfunction

  // Any register except the interrupt counter
  function automatic logic [4:0] randReg();
    logic [31:0] r;
    r = nextRand();
    if (r[4:0] == 5'(INT_REG)) begin
      return 5'(INT_REG + 1);
    end
    return r[4:0];
  endfunction

  function automatic logic [31:0] randAluInstr(input logic immOnly);
    logic [31:0] r;
    logic [5:0] opc;
    logic [31:0] instr;
    r = nextRand();
    opc = aluOps[r[3:0]];
    // Opcode bit 3 selects the immediate form
    if (immOnly) begin
      opc[3] = 1'b1;
    end
    instr = {opc, randReg(), randReg(), r[31:16]};
    if (!opc[3]) begin
      instr[15:11] = randReg();
    end
    return instr;
  endfunction

  function automatic logic isKnownOp(input logic [5:0] opc);
    return opc inside {6'o00, 6'o01, 6'o10, 6'o11, 6'o40, 6'o41, 6'o42,
                       6'o50, 6'o51, 6'o52, 6'o54};
  endfunction

  task automatic checkValue(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("ERROR %0t ns: %s got %08h, expected %08h", $time, what, got, exp);
      errors++;
    end
  endtask

  // Called 1 ns after a rising edge and returns at the same phase
  task automatic apbAccess(input logic write, input logic [11:0] addr, input logic [31:0] wdata,
                           output logic [31:0] rdata, output logic err);
    apbReq.paddr = addr;
    apbReq.pwrite = write;
    apbReq.pwdata = wdata;
    apbReq.psel = 1'b1;
    apbReq.penable = 1'b0;
    @(posedge gclk);
    #1;
    apbReq.penable = 1'b1;
    @(negedge gclk);
    while (!apbRsp.pready) begin
      @(negedge gclk);
    end
    rdata = apbRsp.prdata;
    err = apbRsp.pslverr;
    @(posedge gclk);
    #1;
    apbReq.psel = 1'b0;
    apbReq.penable = 1'b0;
  endtask

  task automatic issueInstr(input logic [31:0] instr);
    logic [31:0] rdata;
    logic err;
    apbAccess(1'b1, ADDR_INSTR, instr, rdata, err);
    checkValue($sformatf("pslverr on instruction %08h", instr), 32'(err), 32'd0);
    modelApply(instr);
  endtask

  task automatic readReg(input logic [4:0] r, output logic [31:0] value);
    logic err;
    apbAccess(1'b0, ADDR_REGBASE + {5'd0, r, 2'b00}, 32'd0, value, err);
    checkValue($sformatf("pslverr on read of r%0d", r), 32'(err), 32'd0);
  endtask

  task automatic checkAllRegs(input string tag);
    logic [31:0] value;
    logic [4:0] r;
    for (int n = 0; n < 32; n++) begin
      r = 5'(n);
      readReg(r, value);
      checkValue($sformatf("%s r%0d", tag, n), value, modelRegs[r]);
    end
  endtask

  task automatic expectError(input logic write, input logic [11:0] addr, input logic [31:0] data);
    logic [31:0] rdata;
    logic err;
    apbAccess(write, addr, data, rdata, err);
    checkValue($sformatf("pslverr at %03h write=%0b", addr, write), 32'(err), 32'd1);
    checkValue($sformatf("prdata at %03h write=%0b", addr, write), rdata, 32'd0);
  endtask

  task automatic idleCycles(input int n);
    repeat (n) @(posedge gclk);
    #1;
  endtask

  task automatic reportTest(input int num, input string name, input int errsBefore);
    $display("Test %0d %s: %s", num, name, (errors == errsBefore) ? "ok" : "FAILED");
  endtask

  // Interrupt pulses two cycles wide and at least 12 cycles apart
  initial begin
    intReq = 1'b0;
    forever begin
      @(posedge gclk);
      if (pulseOn) begin
        #1 intReq = 1'b1;
        repeat (2) @(posedge gclk);
        #1 intReq = 1'b0;
        pulseCount++;
        if (intEnableModel) begin
          modelInterrupt();
        end
        repeat (12) @(posedge gclk);
      end
    end
  end

  initial begin
    int errsBefore;
    logic [31:0] rdata;
    logic [31:0] word;
    logic [31:0] countBefore;
    logic err;
    apbReq = '0;
    grst = 1'b1;
    modelReset();
    repeat (3) @(posedge gclk);
    #1;
    grst = 1'b0;

    errsBefore = errors;
    checkAllRegs("reset");
    apbAccess(1'b0, ADDR_CTRL, 32'd0, rdata, err);
    checkValue("ctrl after reset", rdata, 32'd0);
    reportTest(1, "after-reset reads", errsBefore);

    errsBefore = errors;
    for (int n = 0; n < NUM_RANDOM; n++) begin
      issueInstr(randAluInstr(1'b0));
    end
    checkAllRegs("random");
    reportTest(2, "random instructions", errsBefore);

    errsBefore = errors;
    // imm 0xABCD then ori r5, r0, 0x1234
    issueInstr({6'o54, 10'd0, 16'hABCD});
    issueInstr({6'o50, 5'd5, 5'd0, 16'h1234});
    readReg(5'd5, rdata);
    checkValue("prefixed ori r5", rdata, 32'hABCD1234);
    // Unprefixed addi sign-extends
    issueInstr({6'o10, 5'd6, 5'd0, 16'h8001});
    readReg(5'd6, rdata);
    checkValue("sign-extended addi r6", rdata, 32'hFFFF8001);
    for (int n = 0; n < NUM_IMM_ROUNDS; n++) begin
      word = nextRand();
      if (word[0]) begin
        issueInstr({6'o54, 10'd0, word[31:16]});
      end
      issueInstr(randAluInstr(1'b1));
    end
    checkAllRegs("imm");
    reportTest(3, "IMM prefixes", errsBefore);

    errsBefore = errors;
    apbAccess(1'b1, ADDR_CTRL, 32'd1, rdata, err);
    intEnableModel = 1'b1;
    apbAccess(1'b0, ADDR_CTRL, 32'd0, rdata, err);
    checkValue("ctrl readback", rdata, 32'd1);
    pulseOn = 1'b1;
    for (int n = 0; n < NUM_INT_OPS; n++) begin
      word = nextRand();
      if (word[2:0] == 3'd0) begin
        issueInstr({6'o54, 10'd0, word[31:16]});
        issueInstr(randAluInstr(1'b1));
      end else begin
        issueInstr(randAluInstr(1'b0));
      end
    end
    pulseOn = 1'b0;
    idleCycles(24);
    readReg(5'(INT_REG), rdata);
    checkValue("interrupt counter", rdata, 32'(pulseCount));
    checkAllRegs("irq enabled");
    apbAccess(1'b1, ADDR_CTRL, 32'd0, rdata, err);
    intEnableModel = 1'b0;
    countBefore = modelRegs[INT_REG];
    pulseOn = 1'b1;
    for (int n = 0; n < NUM_QUIET_OPS; n++) begin
      issueInstr(randAluInstr(1'b0));
    end
    idleCycles(40);
    pulseOn = 1'b0;
    idleCycles(24);
    readReg(5'(INT_REG), rdata);
    checkValue("counter with irq disabled", rdata, countBefore);
    checkAllRegs("irq disabled");
    reportTest(4, "interrupt counting", errsBefore);

    errsBefore = errors;
    for (int n = 0; n < 8; n++) begin
      expectError(1'b0, badAddrs[3'(n)], 32'd0);
      expectError(1'b1, badAddrs[3'(n)], nextRand());
    end
    for (int n = 0; n < 4; n++) begin
      expectError(1'b1, ADDR_REGBASE + {5'd0, randReg(), 2'b00}, nextRand());
    end
    expectError(1'b0, ADDR_INSTR, 32'd0);
    for (int n = 0; n < NUM_UNKNOWN; n++) begin
      word = nextRand();
      while (isKnownOp(word[31:26])) begin
        word = nextRand();
      end
      issueInstr(word);
    end
    checkAllRegs("errors");
    reportTest(5, "error responses", errsBefore);

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: logic/miniCore.sv
`timescale 1ns/1ns

module miniCore #(
  parameter int intCountReg = 14
) (
  input  logic             gclk,
  input  logic             grst,
  input  corePkg::apbReq_t apbReq,
  output corePkg::apbRsp_t apbRsp,
  input  logic             intReq
);
  import corePkg::*;

  logic acceptReady;
  logic pipeBusy;
  logic hostValid;
  logic [31:0] hostInstr;
  logic intEnable;
  logic [4:0] regRdAddr;
  logic [31:0] regRdData;
  logic [4:0] rdAddrA;
  logic [4:0] rdAddrB;
  logic [31:0] rdDataA;
  logic [31:0] rdDataB;
  logic wrEn;
  logic [4:0] wrAddr;
  logic [31:0] wrData;
  issueWord_t issue;
  decodedOp_t op;
  result_t res;
  result_t wbFwd;

  hostPort uHostPort (
    .gclk, .grst, .apbReq, .apbRsp, .acceptReady, .pipeBusy, .regRdData,
    .hostValid, .hostInstr, .intEnable, .regRdAddr
  );

  instrBuffer #(.intCountReg(intCountReg)) uInstrBuffer (
    .gclk, .grst, .hostValid, .hostInstr, .intEnable, .intReq, .acceptReady, .issue
  );

  decodeStage uDecode (
    .gclk, .grst, .issue, .rdAddrA, .rdAddrB, .rdDataA, .rdDataB,
    .exFwd(res), .wbFwd, .op
  );

  regFile uRegFile (
    .gclk, .rdAddrA, .rdAddrB, .rdAddrC(regRdAddr), .rdDataA, .rdDataB,
    .rdDataC(regRdData), .wrEn, .wrAddr, .wrData
  );

  executeStage uExecute (.gclk, .grst, .op, .res);

  resultStage uResult (
    .gclk, .grst, .res, .decValid(issue.valid), .exValid(op.valid),
    .wrEn, .wrAddr, .wrData, .wbFwd, .pipeBusy
  );

endmodule

// File: logic/resultStage.sv
`timescale 1ns/1ns

module resultStage (
  input  logic             gclk,
  input  logic             grst,
  input  corePkg::result_t res,
  input  logic             decValid,
  input  logic             exValid,
  output logic             wrEn,
  output logic [4:0]       wrAddr,
  output logic [31:0]      wrData,
  output corePkg::result_t wbFwd,
  output logic             pipeBusy
);
  import corePkg::*;

  result_t wbReg;

  always_ff @(posedge gclk) begin
    wbReg <= res;
    if (grst) begin
      wbReg.valid <= 1'b0;
    end
  end

  assign wrEn = wbReg.valid;
  assign wrAddr = wbReg.rd;
  assign wrData = wbReg.value;
  assign wbFwd = wbReg;

  // Busy until the last write has reached the register file
  assign pipeBusy = decValid || exValid || res.valid || wbReg.valid;

  noWriteToR0: assert property (@(posedge gclk) disable iff (grst)
    wrEn |-> (wrAddr != 5'd0));

endmodule

// File: logic/executeStage.sv
`timescale 1ns/1ns

module executeStage (
  input  logic                gclk,
  input  logic                grst,
  input  corePkg::decodedOp_t op,
  output corePkg::result_t    res
);
  import corePkg::*;

  logic [31:0] aluOut;
  result_t nextRes;

  always_comb begin
    case (op.aluOp)
      ALU_ADD:  aluOut = op.opA + op.opB;
      ALU_RSUB: aluOut = op.opB - op.opA;   // reverse subtract
      ALU_AND:  aluOut = op.opA & op.opB;
      ALU_OR:   aluOut = op.opA | op.opB;
      ALU_XOR:  aluOut = op.opA ^ op.opB;
      default:  aluOut = 32'd0;
    endcase
  end

  // Only real register writes travel on
  always_comb begin
    nextRes.valid = op.valid && (op.aluOp != ALU_NOP) && (op.rd != 5'd0);
    nextRes.rd = op.rd;
    nextRes.value = aluOut;
  end

  always_ff @(posedge gclk) begin
    res <= nextRes;
    if (grst) begin
      res.valid <= 1'b0;
    end
  end

endmodule

// File: logic/regFile.sv
`timescale 1ns/1ns

module regFile (
  input  logic        gclk,
  input  logic [4:0]  rdAddrA,
  input  logic [4:0]  rdAddrB,
  input  logic [4:0]  rdAddrC,
  output logic [31:0] rdDataA,
  output logic [31:0] rdDataB,
  output logic [31:0] rdDataC,
  input  logic        wrEn,
  input  logic [4:0]  wrAddr,
  input  logic [31:0] wrData
);

  // Power-up contents are zero
  logic [31:0] mem [32] = '{default: '0};

  always_ff @(posedge gclk) begin
    if (wrEn && wrAddr != 5'd0) begin
      mem[wrAddr] <= wrData;
    end
  end

  // r0 always reads zero
  assign rdDataA = (rdAddrA == 5'd0) ? 32'd0 : mem[rdAddrA];
  assign rdDataB = (rdAddrB == 5'd0) ? 32'd0 : mem[rdAddrB];
  assign rdDataC = (rdAddrC == 5'd0) ? 32'd0 : mem[rdAddrC];

endmodule

// File: logic/decodeStage.sv
`timescale 1ns/1ns

module decodeStage (
  input  logic                gclk,
  input  logic                grst,
  input  corePkg::issueWord_t issue,
  output logic [4:0]          rdAddrA,
  output logic [4:0]          rdAddrB,
  input  logic [31:0]         rdDataA,
  input  logic [31:0]         rdDataB,
  input  corePkg::result_t    exFwd,
  input  corePkg::result_t    wbFwd,
  output corePkg::decodedOp_t op
);
  import corePkg::*;

  opcode_t opc;
  aluOp_t aluOp;
  logic useImm;
  logic [31:0] immExt;
  decodedOp_t nextOp;

  // Execute result is newer than write-back, so it wins
  function automatic logic [31:0] bypass(input logic [4:0] addr, input logic [31:0] regVal,
                                         input result_t ex, input result_t wb);
    logic [31:0] val;
    val = regVal;
    if (addr != 5'd0) begin
      if (ex.valid && ex.rd == addr) begin
        val = ex.value;
      end else if (wb.valid && wb.rd == addr) begin
        val = wb.value;
      end
    end
    return val;
  endfunction

  assign opc = opcode_t'(issue.instr[31:26]);
  assign rdAddrA = issue.instr[20:16];
  assign rdAddrB = issue.instr[15:11];

  assign immExt = issue.immPrefixed ? {issue.immHigh, issue.instr[15:0]} :
                                      {{16{issue.instr[15]}}, issue.instr[15:0]};

  always_comb begin
    useImm = 1'b0;
    case (opc)
      OP_ADD:   aluOp = ALU_ADD;
      OP_RSUB:  aluOp = ALU_RSUB;
      OP_OR:    aluOp = ALU_OR;
      OP_AND:   aluOp = ALU_AND;
      OP_XOR:   aluOp = ALU_XOR;
      OP_ADDI:  begin aluOp = ALU_ADD;  useImm = 1'b1; end
      OP_RSUBI: begin aluOp = ALU_RSUB; useImm = 1'b1; end
      OP_ORI:   begin aluOp = ALU_OR;   useImm = 1'b1; end
      OP_ANDI:  begin aluOp = ALU_AND;  useImm = 1'b1; end
      OP_XORI:  begin aluOp = ALU_XOR;  useImm = 1'b1; end
      default:  aluOp = ALU_NOP;   // IMM and unknown opcodes
    endcase
  end

  always_comb begin
    nextOp.valid = issue.valid;
    nextOp.aluOp = aluOp;
    nextOp.rd = issue.instr[25:21];
    nextOp.opA = bypass(rdAddrA, rdDataA, exFwd, wbFwd);
    nextOp.opB = useImm ? immExt : bypass(rdAddrB, rdDataB, exFwd, wbFwd);
  end

  always_ff @(posedge gclk) begin
    op <= nextOp;
    if (grst) begin
      op.valid <= 1'b0;
    end
  end

endmodule

// File: logic/instrBuffer.sv
`timescale 1ns/1ns

module instrBuffer #(
  parameter int intCountReg = 14
) (
  input  logic                gclk,
  input  logic                grst,
  input  logic                hostValid,
  input  logic [31:0]         hostInstr,
  input  logic                intEnable,
  input  logic                intReq,
  output logic                acceptReady,
  output corePkg::issueWord_t issue
);
  import corePkg::*;

  localparam logic [4:0] CNT_REG = 5'(intCountReg);
  // addi rCnt, rCnt, 1
  localparam logic [31:0] INT_WORD = {OP_ADDI, CNT_REG, CNT_REG, 16'h0001};

  logic [1:0] intSync;
  logic intSyncLast;
  logic intRise;
  logic intPending;
  logic lastWasImm;
  logic [15:0] immHold;
  logic issueInjected;
  logic slotBlocked;
  logic counterHazard;
  logic injectNow;
  logic hostTake;
  logic hostIsImm;
  issueWord_t nextWord;

  // Interrupt path runs every cycle regardless of stalls
  always_ff @(posedge gclk) begin
    if (grst) begin
      intSync <= 2'b00;
      intSyncLast <= 1'b0;
      intPending <= 1'b0;
    end else begin
      intSync <= {intSync[0], intReq};
      intSyncLast <= intSync[1];
      intPending <= (intPending && !injectNow) || (intRise && intEnable);
    end
  end

  assign intRise = intSync[1] && !intSyncLast;

  // The word issued last cycle is still one stage short of the bypass paths
  assign slotBlocked = issue.valid && (issue.instr[25:21] == CNT_REG);
  assign counterHazard = issueInjected &&
                         (hostInstr[20:16] == CNT_REG || hostInstr[15:11] == CNT_REG);

  // Never split an IMM prefix from its instruction
  assign injectNow = intPending && !lastWasImm && !slotBlocked;
  assign acceptReady = !injectNow && !counterHazard;
  assign hostTake = hostValid && acceptReady;
  assign hostIsImm = hostInstr[31:26] == OP_IMM;

  always_comb begin
    nextWord = '0;
    nextWord.immHigh = immHold;
    if (injectNow) begin
      nextWord.valid = 1'b1;
      nextWord.instr = INT_WORD;
    end else if (hostTake) begin
      nextWord.valid = 1'b1;
      nextWord.instr = hostInstr;
      nextWord.immPrefixed = lastWasImm;
    end
  end

  always_ff @(posedge gclk) begin
    issue <= nextWord;
    if (grst) begin
      issue.valid <= 1'b0;
    end
  end

  always_ff @(posedge gclk) begin
    if (grst) begin
      lastWasImm <= 1'b0;
      issueInjected <= 1'b0;
    end else begin
      issueInjected <= injectNow;
      if (hostTake) begin
        lastWasImm <= hostIsImm;
      end
    end
  end

  // High half for the next immediate
  always_ff @(posedge gclk) begin
    if (hostTake && hostIsImm) begin
      immHold <= hostInstr[15:0];
    end
  end

  noInjectAfterImm: assert property (@(posedge gclk) disable iff (grst)
    (issue.valid && issue.instr[31:26] == OP_IMM) |=> !issueInjected);

endmodule

// File: logic/hostPort.sv
`timescale 1ns/1ns

module hostPort (
  input  logic             gclk,
  input  logic             grst,
  input  corePkg::apbReq_t apbReq,
  output corePkg::apbRsp_t apbRsp,
  input  logic             acceptReady,
  input  logic             pipeBusy,
  input  logic [31:0]      regRdData,
  output logic             hostValid,
  output logic [31:0]      hostInstr,
  output logic             intEnable,
  output logic [4:0]       regRdAddr
);
  import corePkg::*;

  logic accessPhase;
  logic isInstr;
  logic isCtrl;
  logic isReg;
  logic badAccess;

  assign accessPhase = apbReq.psel && apbReq.penable;
  assign isInstr = apbReq.paddr == ADDR_INSTR;
  assign isCtrl = apbReq.paddr == ADDR_CTRL;
  // Register window 0x080..0x0FC on word boundaries
  assign isReg = (apbReq.paddr[11:7] == ADDR_REGBASE[11:7]) && (apbReq.paddr[1:0] == 2'b00);

  // Instruction port is write only and the register window is read only
  assign badAccess = (isInstr && !apbReq.pwrite) || (isReg && apbReq.pwrite) ||
                     !(isInstr || isCtrl || isReg);

  assign hostValid = accessPhase && isInstr && apbReq.pwrite;
  assign hostInstr = apbReq.pwdata;
  assign regRdAddr = apbReq.paddr[6:2];

  always_comb begin
    apbRsp = '0;
    if (accessPhase) begin
      if (badAccess) begin
        apbRsp.pready = 1'b1;
        apbRsp.pslverr = 1'b1;
      end else if (isInstr) begin
        apbRsp.pready = acceptReady;
      end else if (isCtrl) begin
        apbRsp.pready = 1'b1;
        if (!apbReq.pwrite) begin
          apbRsp.prdata = {31'd0, intEnable};
        end
      end else begin
        // Hold reads off until every earlier instruction has written back
        apbRsp.pready = !pipeBusy;
        if (!pipeBusy) begin
          apbRsp.prdata = regRdData;
        end
      end
    end
  end

  // Bit0 of the control register enables interrupts
  always_ff @(posedge gclk) begin
    if (grst) begin
      intEnable <= 1'b0;
    end else if (accessPhase && isCtrl && apbReq.pwrite) begin
      intEnable <= apbReq.pwdata[0];
    end
  end

  // An access phase follows a setup cycle or a waited access cycle
  readyInAccess: assert property (@(posedge gclk) disable iff (grst)
    apbRsp.pready |-> accessPhase &&
                      $past(apbReq.psel && !(apbReq.penable && apbRsp.pready)));

endmodule

// File: logic/corePkg.sv
package corePkg;

  // Major opcodes held in instr[31:26]
  typedef enum logic [5:0] {
    OP_ADD   = 6'o00,
    OP_RSUB  = 6'o01,
    OP_ADDI  = 6'o10,
    OP_RSUBI = 6'o11,
    OP_OR    = 6'o40,
    OP_AND   = 6'o41,
    OP_XOR   = 6'o42,
    OP_ORI   = 6'o50,
    OP_ANDI  = 6'o51,
    OP_XORI  = 6'o52,
    OP_IMM   = 6'o54
  } opcode_t;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_RSUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_NOP
  } aluOp_t;

  typedef struct packed {
    logic [11:0] paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
  } apbReq_t;

  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apbRsp_t;

  // Word handed from the instruction buffer to decode
  typedef struct packed {
    logic        valid;
    logic [31:0] instr;
    logic [15:0] immHigh;
    logic        immPrefixed;
    logic [20:0] reserved;
  } issueWord_t;

  typedef struct packed {
    logic        valid;
    aluOp_t      aluOp;
    logic [4:0]  rd;
    logic [31:0] opA;
    logic [31:0] opB;
  } decodedOp_t;

  typedef struct packed {
    logic        valid;
    logic [4:0]  rd;
    logic [31:0] value;
  } result_t;

  // APB register map
  localparam logic [11:0] ADDR_INSTR   = 12'h000;
  localparam logic [11:0] ADDR_CTRL    = 12'h004;
  localparam logic [11:0] ADDR_REGBASE = 12'h080;

endpackage
